/* src/read_buffer_pkg.sv */
package read_buffer_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // 16 tags in flight
  parameter int TAG_WIDTH = 4;

  // One parity-protected doubleword
  parameter int DWORD_WIDTH = 64;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  //////////////////////////////////////////////////
  // Command and response encodings
  //////////////////////////////////////////////////

  // Command that fetched the line
  typedef enum logic [1:0] {
    CMD_NONE = 2'd0,
    CMD_READ = 2'd1,
    CMD_WED  = 2'd2
  } cmd_kind_e;

  // Host response code
  typedef enum logic [1:0] {
    RESP_DONE  = 2'd0,
    RESP_NLOCK = 2'd1,
    RESP_FAULT = 2'd2
  } resp_code_e;

endpackage

/* src/tag_line_ram.sv */
`timescale 1ns/1ps

module tag_line_ram #(
  parameter int WIDTH = 128,
  parameter int DEPTH = 16
) (
  input  logic                  clock,
  input  logic                  we,
  input  read_buffer_pkg::tag_t wr_addr,
  input  logic [WIDTH-1:0]      wr_data,
  input  read_buffer_pkg::tag_t rd_addr,
  output logic [WIDTH-1:0]      rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Same-address read during a write returns old data
  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

/* src/read_beat_capture.sv */
`timescale 1ns/1ps

module read_beat_capture #(
  parameter  int HALF_DWORDS = 2,
  localparam int HALF_WIDTH  = HALF_DWORDS * read_buffer_pkg::DWORD_WIDTH
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       beat_valid,
  input  logic                       beat_half,
  input  read_buffer_pkg::tag_t      beat_tag,
  input  logic                       beat_tag_par,
  input  read_buffer_pkg::cmd_kind_e beat_kind,
  input  logic [HALF_WIDTH-1:0]      beat_data,
  input  logic [HALF_DWORDS-1:0]     beat_data_par,
  output logic                       cap_valid,
  output logic                       cap_half,
  output read_buffer_pkg::tag_t      cap_tag,
  output read_buffer_pkg::cmd_kind_e cap_kind,
  output logic [HALF_WIDTH-1:0]      cap_data,
  output logic [1:0]                 parity_error
);

  localparam int DW = read_buffer_pkg::DWORD_WIDTH;

  logic                   tag_par_q;
  logic [HALF_DWORDS-1:0] data_par_q;
  logic                   tag_bad;
  logic [HALF_DWORDS-1:0] dword_bad;

  //////////////////////////////////////////////////
  // Input latch
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= beat_valid;
    end
  end

  always_ff @(posedge clock) begin
    cap_half   <= beat_half;
    cap_tag    <= beat_tag;
    cap_kind   <= beat_kind;
    cap_data   <= beat_data;
    tag_par_q  <= beat_tag_par;
    data_par_q <= beat_data_par;
  end

  //////////////////////////////////////////////////
  // Odd parity check
  //////////////////////////////////////////////////

  // Field plus its parity bit must hold an odd count of ones
  assign tag_bad = ~(^{cap_tag, tag_par_q});

  always_comb begin
    dword_bad = '0;
    for (int i = 0; i < HALF_DWORDS; i++) begin
      dword_bad[i] = ~(^{cap_data[i*DW +: DW], data_par_q[i]});
    end
  end

  // Upper bit tag, lower bit data
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      parity_error <= 2'b00;
    end else if (cap_valid) begin
      parity_error <= {tag_bad, |dword_bad};
    end else begin
      parity_error <= 2'b00;
    end
  end

  // Error flag only ever follows a latched beat
  assert property (@(posedge clock) disable iff (!rstn)
    (|parity_error) |-> $past(cap_valid));

endmodule

/* src/read_line_store.sv */
`timescale 1ns/1ps

module read_line_store #(
  parameter  int HALF_DWORDS = 2,
  localparam int HALF_WIDTH  = HALF_DWORDS * read_buffer_pkg::DWORD_WIDTH
) (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        cap_valid,
  input  logic                        cap_half,
  input  read_buffer_pkg::tag_t       cap_tag,
  input  read_buffer_pkg::cmd_kind_e  cap_kind,
  input  logic [HALF_WIDTH-1:0]       cap_data,
  input  logic                        resp_valid,
  output logic                        resp_ready,
  input  read_buffer_pkg::tag_t       resp_tag,
  input  read_buffer_pkg::resp_code_e resp_code,
  output logic                        line_valid,
  input  logic                        line_ready,
  output read_buffer_pkg::tag_t       line_tag,
  output read_buffer_pkg::cmd_kind_e  line_kind,
  output logic [HALF_WIDTH-1:0]       line_data_lo,
  output logic [HALF_WIDTH-1:0]       line_data_hi
);

  localparam int TAG_COUNT = 1 << read_buffer_pkg::TAG_WIDTH;

  logic                        resp_fire;
  logic                        pend_valid;
  read_buffer_pkg::tag_t       pend_tag;
  read_buffer_pkg::resp_code_e pend_code;
  logic                        we_lo;
  logic                        we_hi;
  logic [TAG_COUNT-1:0]        present_lo;
  logic [TAG_COUNT-1:0]        present_hi;
  read_buffer_pkg::cmd_kind_e  kind_mem [TAG_COUNT];

  // One response in flight until the release stage is idle again
  assign resp_ready = line_ready && !line_valid && !pend_valid;
  assign resp_fire  = resp_valid && resp_ready;

  assign we_lo = cap_valid && !cap_half;
  assign we_hi = cap_valid && cap_half;

  //////////////////////////////////////////////////
  // Half storage
  //////////////////////////////////////////////////

  tag_line_ram #(.WIDTH(HALF_WIDTH), .DEPTH(TAG_COUNT)) ram_lo_inst (
    .clock  (clock),
    .we     (we_lo),
    .wr_addr(cap_tag),
    .wr_data(cap_data),
    .rd_addr(pend_tag),
    .rd_data(line_data_lo)
  );

  tag_line_ram #(.WIDTH(HALF_WIDTH), .DEPTH(TAG_COUNT)) ram_hi_inst (
    .clock  (clock),
    .we     (we_hi),
    .wr_addr(cap_tag),
    .wr_data(cap_data),
    .rd_addr(pend_tag),
    .rd_data(line_data_hi)
  );

  always_ff @(posedge clock) begin
    if (cap_valid) begin
      kind_mem[cap_tag] <= cap_kind;
    end
  end

  //////////////////////////////////////////////////
  // Response latch and presence tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (resp_fire) begin
      pend_tag  <= resp_tag;
      pend_code <= resp_code;
    end
    if (pend_valid) begin
      line_tag  <= pend_tag;
      line_kind <= kind_mem[pend_tag];
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      pend_valid <= 1'b0;
      line_valid <= 1'b0;
      present_lo <= '0;
      present_hi <= '0;
    end else begin
      pend_valid <= resp_fire;
      // No-lock drops the line but still frees the tag
      if (pend_valid) begin
        line_valid           <= (pend_code != read_buffer_pkg::RESP_NLOCK);
        present_lo[pend_tag] <= 1'b0;
        present_hi[pend_tag] <= 1'b0;
      end else if (line_ready) begin
        line_valid <= 1'b0;
      end
      if (we_lo) begin
        present_lo[cap_tag] <= 1'b1;
      end
      if (we_hi) begin
        present_hi[cap_tag] <= 1'b1;
      end
    end
  end

  // Host confirms only lines whose halves both landed
  assert property (@(posedge clock) disable iff (!rstn)
    resp_fire |-> present_lo[resp_tag] && present_hi[resp_tag]);

  // No duplicate half for a live tag
  assert property (@(posedge clock) disable iff (!rstn)
    cap_valid |-> !(cap_half ? present_hi[cap_tag] : present_lo[cap_tag]));

endmodule

/* src/line_release.sv */
`timescale 1ns/1ps

module line_release #(
  parameter  int HALF_DWORDS = 2,
  localparam int HALF_WIDTH  = HALF_DWORDS * read_buffer_pkg::DWORD_WIDTH
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       line_valid,
  output logic                       line_ready,
  input  read_buffer_pkg::tag_t      line_tag,
  input  read_buffer_pkg::cmd_kind_e line_kind,
  input  logic [HALF_WIDTH-1:0]      line_data_lo,
  input  logic [HALF_WIDTH-1:0]      line_data_hi,
  output logic                       out_valid,
  input  logic                       out_ready,
  output read_buffer_pkg::tag_t      out_tag,
  output read_buffer_pkg::cmd_kind_e out_kind,
  output logic                       out_half,
  output logic                       out_last,
  output logic [HALF_WIDTH-1:0]      out_data
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    SEND_LO = 2'd1,
    SEND_HI = 2'd2
  } state_e;

  state_e                state;
  logic [HALF_WIDTH-1:0] data_lo_q;
  logic [HALF_WIDTH-1:0] data_hi_q;

  assign line_ready = (state == IDLE);

  //////////////////////////////////////////////////
  // Output FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (line_valid) state <= SEND_LO;
        SEND_LO: if (out_ready) state <= SEND_HI;
        SEND_HI: if (out_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Hold the whole line while its halves drain
  always_ff @(posedge clock) begin
    if (line_valid && line_ready) begin
      out_tag   <= line_tag;
      out_kind  <= line_kind;
      data_lo_q <= line_data_lo;
      data_hi_q <= line_data_hi;
    end
  end

  assign out_valid = (state != IDLE);
  assign out_half  = (state == SEND_HI);
  assign out_last  = (state == SEND_HI);
  assign out_data  = (state == SEND_HI) ? data_hi_q : data_lo_q;

  // Stalled beat keeps every field
  assert property (@(posedge clock) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_tag) && $stable(out_kind)
      && $stable(out_half) && $stable(out_last) && $stable(out_data));

endmodule

/* src/read_buffer_top.sv */
`timescale 1ns/1ps

module read_buffer_top #(
  parameter  int HALF_DWORDS = 2,
  localparam int HALF_WIDTH  = HALF_DWORDS * read_buffer_pkg::DWORD_WIDTH
) (
  input  logic                        clock,
  input  logic                        rstn,
  // Beat input from the host bus
  input  logic                        beat_valid,
  input  logic                        beat_half,
  input  read_buffer_pkg::tag_t       beat_tag,
  input  logic                        beat_tag_par,
  input  read_buffer_pkg::cmd_kind_e  beat_kind,
  input  logic [HALF_WIDTH-1:0]       beat_data,
  input  logic [HALF_DWORDS-1:0]      beat_data_par,
  // Host response
  input  logic                        resp_valid,
  output logic                        resp_ready,
  input  read_buffer_pkg::tag_t       resp_tag,
  input  read_buffer_pkg::resp_code_e resp_code,
  // Released line
  output logic                        out_valid,
  input  logic                        out_ready,
  output read_buffer_pkg::tag_t       out_tag,
  output read_buffer_pkg::cmd_kind_e  out_kind,
  output logic                        out_half,
  output logic                        out_last,
  output logic [HALF_WIDTH-1:0]       out_data,
  output logic [1:0]                  parity_error
);

  logic                       cap_valid;
  logic                       cap_half;
  read_buffer_pkg::tag_t      cap_tag;
  read_buffer_pkg::cmd_kind_e cap_kind;
  logic [HALF_WIDTH-1:0]      cap_data;

  logic                       line_valid;
  logic                       line_ready;
  read_buffer_pkg::tag_t      line_tag;
  read_buffer_pkg::cmd_kind_e line_kind;
  logic [HALF_WIDTH-1:0]      line_data_lo;
  logic [HALF_WIDTH-1:0]      line_data_hi;

  read_beat_capture #(.HALF_DWORDS(HALF_DWORDS)) read_beat_capture_inst (
    .clock        (clock),
    .rstn         (rstn),
    .beat_valid   (beat_valid),
    .beat_half    (beat_half),
    .beat_tag     (beat_tag),
    .beat_tag_par (beat_tag_par),
    .beat_kind    (beat_kind),
    .beat_data    (beat_data),
    .beat_data_par(beat_data_par),
    .cap_valid    (cap_valid),
    .cap_half     (cap_half),
    .cap_tag      (cap_tag),
    .cap_kind     (cap_kind),
    .cap_data     (cap_data),
    .parity_error (parity_error)
  );

  read_line_store #(.HALF_DWORDS(HALF_DWORDS)) read_line_store_inst (
    .clock       (clock),
    .rstn        (rstn),
    .cap_valid   (cap_valid),
    .cap_half    (cap_half),
    .cap_tag     (cap_tag),
    .cap_kind    (cap_kind),
    .cap_data    (cap_data),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_tag    (resp_tag),
    .resp_code   (resp_code),
    .line_valid  (line_valid),
    .line_ready  (line_ready),
    .line_tag    (line_tag),
    .line_kind   (line_kind),
    .line_data_lo(line_data_lo),
    .line_data_hi(line_data_hi)
  );

  line_release #(.HALF_DWORDS(HALF_DWORDS)) line_release_inst (
    .clock       (clock),
    .rstn        (rstn),
    .line_valid  (line_valid),
    .line_ready  (line_ready),
    .line_tag    (line_tag),
    .line_kind   (line_kind),
    .line_data_lo(line_data_lo),
    .line_data_hi(line_data_hi),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_tag     (out_tag),
    .out_kind    (out_kind),
    .out_half    (out_half),
    .out_last    (out_last),
    .out_data    (out_data)
  );

endmodule

/* dv/read_buffer_tb.sv */
`timescale 1ns/1ps

module read_buffer_tb;

  localparam int HALF_DWORDS = 2;
  localparam int DW          = read_buffer_pkg::DWORD_WIDTH;
  localparam int HW          = HALF_DWORDS * DW;
  localparam int ROWS        = 10;
  localparam int MAX_CYCLES  = ROWS * 40 + 100;

  logic                        clock;
  logic                        rstn;
  logic                        beat_valid;
  logic                        beat_half;
  read_buffer_pkg::tag_t       beat_tag;
  logic                        beat_tag_par;
  read_buffer_pkg::cmd_kind_e  beat_kind;
  logic [HW-1:0]               beat_data;
  logic [HALF_DWORDS-1:0]      beat_data_par;
  logic                        resp_valid;
  logic                        resp_ready;
  read_buffer_pkg::tag_t       resp_tag;
  read_buffer_pkg::resp_code_e resp_code;
  logic                        out_valid;
  logic                        out_ready;
  read_buffer_pkg::tag_t       out_tag;
  read_buffer_pkg::cmd_kind_e  out_kind;
  logic                        out_half;
  logic                        out_last;
  logic [HW-1:0]               out_data;
  logic [1:0]                  parity_error;

  // Stimulus table with one entry per row
  string                       row_name [ROWS];
  read_buffer_pkg::tag_t       row_tag [ROWS];
  read_buffer_pkg::cmd_kind_e  row_kind [ROWS];
  logic [HW-1:0]               row_lo [ROWS];
  logic [HW-1:0]               row_hi [ROWS];
  bit                          row_hi_first [ROWS];
  bit                          row_pair [ROWS];
  bit                          row_tag_bad [ROWS];
  logic [2*HALF_DWORDS-1:0]    row_dmask [ROWS];
  read_buffer_pkg::resp_code_e row_code [ROWS];
  bit                          row_stall [ROWS];

  int          exp_row [$];
  bit          exp_half [$];
  int          error_count = 0;
  int          cycles = 0;
  bit          stall_mode = 0;
  bit          busy = 0;
  string       busy_name = "";
  logic [1:0]  beat_err = 2'b00;
  string       beat_name = "";
  logic [1:0]  perr_exp1 = 2'b00;
  logic [1:0]  perr_exp2 = 2'b00;
  string       perr_name1 = "reset";
  string       perr_name2 = "reset";
  bit          held = 0;
  string       held_name;
  read_buffer_pkg::tag_t      held_tag;
  read_buffer_pkg::cmd_kind_e held_kind;
  logic                       held_half;
  logic                       held_last;
  logic [HW-1:0]              held_data;
  int          mon_row;
  bit          mon_half;

  read_buffer_top #(.HALF_DWORDS(HALF_DWORDS)) read_buffer_top_inst (
    .clock        (clock),
    .rstn         (rstn),
    .beat_valid   (beat_valid),
    .beat_half    (beat_half),
    .beat_tag     (beat_tag),
    .beat_tag_par (beat_tag_par),
    .beat_kind    (beat_kind),
    .beat_data    (beat_data),
    .beat_data_par(beat_data_par),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp_tag     (resp_tag),
    .resp_code    (resp_code),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_tag      (out_tag),
    .out_kind     (out_kind),
    .out_half     (out_half),
    .out_last     (out_last),
    .out_data     (out_data),
    .parity_error (parity_error)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check(input string test, input string what,
                       input logic [HW-1:0] expected, input logic [HW-1:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s %s: expected %0h actual %0h", test, what, expected, actual);
      stop_run();
    end
  endtask

  // Parity bit that makes the count of ones odd
  function automatic logic odd_parity(input logic [DW-1:0] field);
    int ones;
    ones = 0;
    for (int i = 0; i < DW; i++) begin
      ones += field[i];
    end
    return (ones % 2 == 0);
  endfunction

  task automatic set_row(input int idx, input string name, input read_buffer_pkg::tag_t tag,
                         input read_buffer_pkg::cmd_kind_e kind,
                         input logic [HW-1:0] lo, input logic [HW-1:0] hi,
                         input bit hi_first, input bit pair, input bit tag_bad,
                         input logic [2*HALF_DWORDS-1:0] dmask,
                         input read_buffer_pkg::resp_code_e code, input bit stall);
    row_name[idx]     = name;
    row_tag[idx]      = tag;
    row_kind[idx]     = kind;
    row_lo[idx]       = lo;
    row_hi[idx]       = hi;
    row_hi_first[idx] = hi_first;
    row_pair[idx]     = pair;
    row_tag_bad[idx]  = tag_bad;
    row_dmask[idx]    = dmask;
    row_code[idx]     = code;
    row_stall[idx]    = stall;
  endtask

  // One beat held for one cycle just after a rising edge
  task automatic drive_beat(input int r, input bit half);
    logic [HW-1:0]          data;
    logic [HALF_DWORDS-1:0] par;
    logic                   data_bad;
    data     = half ? row_hi[r] : row_lo[r];
    data_bad = 1'b0;
    for (int i = 0; i < HALF_DWORDS; i++) begin
      par[i]   = odd_parity(data[i*DW +: DW]) ^ row_dmask[r][int'(half)*HALF_DWORDS + i];
      data_bad = data_bad | row_dmask[r][int'(half)*HALF_DWORDS + i];
    end
    beat_valid    = 1'b1;
    beat_half     = half;
    beat_tag      = row_tag[r];
    beat_tag_par  = odd_parity(DW'(row_tag[r])) ^ row_tag_bad[r];
    beat_kind     = row_kind[r];
    beat_data     = data;
    beat_data_par = par;
    beat_err      = {row_tag_bad[r], data_bad};
    beat_name     = row_name[r];
    @(posedge clock);
    #1;
  endtask

  task automatic idle_beats(input int n);
    beat_valid = 1'b0;
    repeat (n) @(posedge clock);
    #1;
  endtask

  task automatic send_resp(input int r);
    bit accepted;
    stall_mode = row_stall[r];
    resp_valid = 1'b1;
    resp_tag   = row_tag[r];
    resp_code  = row_code[r];
    do begin
      @(negedge clock);
      accepted = resp_ready;
      @(posedge clock);
    end while (!accepted);
    #1;
    resp_valid = 1'b0;
    if (row_code[r] != read_buffer_pkg::RESP_NLOCK) begin
      exp_row.push_back(r);
      exp_half.push_back(1'b0);
      exp_row.push_back(r);
      exp_half.push_back(1'b1);
      busy      = 1'b1;
      busy_name = row_name[r];
    end
    // First beat comes two edges after acceptance and never on no-lock
    @(negedge clock);
    check(row_name[r], "out_valid after accept edge", 1'b0, out_valid);
    @(negedge clock);
    check(row_name[r], "out_valid one edge after accept", 1'b0, out_valid);
    @(negedge clock);
    check(row_name[r], "out_valid two edges after accept",
          row_code[r] != read_buffer_pkg::RESP_NLOCK, out_valid);
    @(posedge clock);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////

  always @(posedge clock) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      stop_run();
    end
  end

  // Random out_ready stalls only while a stalled row drains
  initial begin
    void'($urandom(32'hec25a8fc));
    out_ready = 1'b1;
    forever begin
      @(posedge clock);
      #1;
      out_ready = stall_mode ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  always @(negedge clock) begin
    check(perr_name2, "parity_error", perr_exp2, parity_error);
    perr_exp2  = perr_exp1;
    perr_name2 = perr_name1;
    perr_exp1  = beat_valid ? beat_err : 2'b00;
    perr_name1 = beat_name;
    if (busy) begin
      check(busy_name, "resp_ready while line drains", 1'b0, resp_ready);
    end
    if (held) begin
      check(held_name, "out_valid held", 1'b1, out_valid);
      check(held_name, "out_tag held", held_tag, out_tag);
      check(held_name, "out_kind held", held_kind, out_kind);
      check(held_name, "out_half held", held_half, out_half);
      check(held_name, "out_last held", held_last, out_last);
      check(held_name, "out_data held", held_data, out_data);
    end
    held = out_valid && !out_ready;
    if (held) begin
      held_name = (exp_row.size() != 0) ? row_name[exp_row[0]] : "none";
      held_tag  = out_tag;
      held_kind = out_kind;
      held_half = out_half;
      held_last = out_last;
      held_data = out_data;
    end
    if (out_valid && out_ready) begin
      if (exp_row.size() == 0) begin
        $display("Output beat for tag %0h appeared with no line expected", out_tag);
        stop_run();
      end else begin
        mon_row  = exp_row.pop_front();
        mon_half = exp_half.pop_front();
        check(row_name[mon_row], "out_tag", row_tag[mon_row], out_tag);
        check(row_name[mon_row], "out_kind", row_kind[mon_row], out_kind);
        check(row_name[mon_row], "out_half", mon_half, out_half);
        check(row_name[mon_row], "out_last", mon_half, out_last);
        check(row_name[mon_row], "out_data",
              mon_half ? row_hi[mon_row] : row_lo[mon_row], out_data);
        if (mon_half) begin
          busy = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int r;
    rstn          = 1'b0;
    beat_valid    = 1'b0;
    beat_half     = 1'b0;
    beat_tag      = '0;
    beat_tag_par  = 1'b0;
    beat_kind     = read_buffer_pkg::CMD_NONE;
    beat_data     = '0;
    beat_data_par = '0;
    resp_valid    = 1'b0;
    resp_tag      = '0;
    resp_code     = read_buffer_pkg::RESP_DONE;

    // Columns are name, tag, kind, lo, hi, hi_first, pair, tag_bad, dmask, code, stall
    set_row(0, "clean_done", 4'h1, read_buffer_pkg::CMD_READ,
            128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff,
            128'h1234_5678_9abc_def0_0fed_cba9_8765_4321,
            0, 0, 0, 4'b0000, read_buffer_pkg::RESP_DONE, 0);
    set_row(1, "hi_first", 4'h2, read_buffer_pkg::CMD_WED,
            128'hdead_beef_cafe_f00d_0123_4567_89ab_cdef,
            128'hffff_0000_aaaa_5555_1111_2222_3333_4444,
            1, 0, 0, 4'b0000, read_buffer_pkg::RESP_DONE, 0);
    set_row(2, "interleave_a", 4'h3, read_buffer_pkg::CMD_READ,
            128'h0a0a_0a0a_0a0a_0a0a_a0a0_a0a0_a0a0_a0a0,
            128'h3333_cccc_3333_cccc_5a5a_5a5a_a5a5_a5a5,
            0, 1, 0, 4'b0000, read_buffer_pkg::RESP_DONE, 0);
    set_row(3, "interleave_b", 4'h4, read_buffer_pkg::CMD_WED,
            128'h7777_8888_9999_aaaa_bbbb_cccc_dddd_eeee,
            128'h0102_0304_0506_0708_090a_0b0c_0d0e_0f10,
            1, 0, 0, 4'b0000, read_buffer_pkg::RESP_DONE, 0);
    set_row(4, "nlock_drop", 4'h5, read_buffer_pkg::CMD_READ,
            128'hbad0_bad0_bad0_bad0_bad1_bad1_bad1_bad1,
            128'hbad2_bad2_bad2_bad2_bad3_bad3_bad3_bad3,
            0, 0, 0, 4'b0000, read_buffer_pkg::RESP_NLOCK, 0);
    set_row(5, "reuse_after_nlock", 4'h5, read_buffer_pkg::CMD_WED,
            128'h600d_0000_600d_1111_600d_2222_600d_3333,
            128'h600d_4444_600d_5555_600d_6666_600d_7777,
            0, 0, 0, 4'b0000, read_buffer_pkg::RESP_DONE, 0);
    set_row(6, "tag_parity", 4'h6, read_buffer_pkg::CMD_WED,
            128'h1357_9bdf_2468_ace0_fdb9_7531_0eca_8642,
            128'h0000_0000_0000_0001_8000_0000_0000_0000,
            1, 0, 1, 4'b0000, read_buffer_pkg::RESP_DONE, 0);
    set_row(7, "data_parity", 4'h7, read_buffer_pkg::CMD_READ,
            128'hffff_ffff_ffff_ffff_0000_0000_0000_0000,
            128'h8421_8421_8421_8421_1248_1248_1248_1248,
            0, 0, 0, 4'b0110, read_buffer_pkg::RESP_FAULT, 0);
    set_row(8, "stall_a", 4'h8, read_buffer_pkg::CMD_READ,
            128'h5555_aaaa_5555_aaaa_c3c3_3c3c_c3c3_3c3c,
            128'h9876_5432_10fe_dcba_0f0f_f0f0_0f0f_f0f0,
            0, 0, 0, 4'b0000, read_buffer_pkg::RESP_DONE, 1);
    set_row(9, "stall_b", 4'h9, read_buffer_pkg::CMD_WED,
            128'h0fed_0fed_0fed_0fed_abcd_abcd_abcd_abcd,
            128'h4242_4242_4242_4242_2424_2424_2424_2424,
            1, 0, 0, 4'b1000, read_buffer_pkg::RESP_DONE, 1);

    repeat (3) @(posedge clock);
    #1;
    rstn = 1'b1;
    @(negedge clock);
    check("reset", "out_valid", 1'b0, out_valid);
    check("reset", "parity_error", 2'b00, parity_error);
    check("reset", "resp_ready", 1'b1, resp_ready);
    @(posedge clock);
    #1;

    r = 0;
    while (r < ROWS) begin
      if (row_pair[r]) begin
        // First halves of both tags, then the second halves
        drive_beat(r, row_hi_first[r]);
        drive_beat(r + 1, row_hi_first[r + 1]);
        drive_beat(r, !row_hi_first[r]);
        drive_beat(r + 1, !row_hi_first[r + 1]);
        idle_beats(3);
        send_resp(r);
        send_resp(r + 1);
        r += 2;
      end else begin
        drive_beat(r, row_hi_first[r]);
        drive_beat(r, !row_hi_first[r]);
        idle_beats(3);
        send_resp(r);
        r += 1;
      end
    end

    while (exp_row.size() != 0 || busy) begin
      @(negedge clock);
    end
    repeat (4) @(negedge clock);

    if (error_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

/* read_buffer_top.f */
src/read_buffer_pkg.sv
src/tag_line_ram.sv
src/read_beat_capture.sv
src/read_line_store.sv
src/line_release.sv
src/read_buffer_top.sv
dv/read_buffer_tb.sv

/* Bender.yml */
package:
  name: read_buffer

sources:
  - src/read_buffer_pkg.sv
  - src/tag_line_ram.sv
  - src/read_beat_capture.sv
  - src/read_line_store.sv
  - src/line_release.sv
  - src/read_buffer_top.sv
  - target: test
    files:
      - dv/read_buffer_tb.sv
